// ==== source/swerve_consts.svh ====
// Swerve register file constants
// Address map, channel counts and control bit positions
`ifndef SWERVE_CONSTS_SVH
`define SWERVE_CONSTS_SVH

// Broadcast addresses, 0x00 stays reserved
`define SWERVE_ADDR_ALL      6'h01 // Every motor control register
`define SWERVE_ADDR_ROT_ALL  6'h02 // Rotation control only
`define SWERVE_ADDR_DRV_ALL  6'h03 // Drive control only

// Drive channels, control at base+2n, status at base+2n+1
`define SWERVE_DRV_BASE      6'h04

// Rotation channels, five registers each
`define SWERVE_ROT_BASE      6'h0C
`define SWERVE_ROT_STRIDE    5
`define SWERVE_ROT_CTRL_OFS  0     // Brake, enable, direction, target 11:8
`define SWERVE_ROT_STAT_OFS  1
`define SWERVE_ROT_TGT_OFS   2     // Target angle low byte
`define SWERVE_ROT_CURL_OFS  3     // Current angle low byte
`define SWERVE_ROT_CURH_OFS  4     // Current angle high byte, also command

`define SWERVE_SERVO_BASE    6'h30

// Channel counts
`define SWERVE_NUM_DRV       4
`define SWERVE_NUM_ROT       4
`define SWERVE_NUM_SERVO     4
`define SWERVE_NUM_MOTOR     8     // Drive plus rotation
`define SWERVE_NUM_CTRL      16    // Writable registers

// Select vector layout
`define SWERVE_SEL_DRV       0
`define SWERVE_SEL_ROT       4
`define SWERVE_SEL_TGT       8
`define SWERVE_SEL_SERVO     12

// Bit positions
`define SWERVE_BIT_BRAKE     7
`define SWERVE_BIT_ENABLE    6
`define SWERVE_BIT_DIR       5
`define SWERVE_BIT_ABORT     4
`define SWERVE_BIT_UPDATE    5
`define SWERVE_BIT_DONE      7     // In current angle high byte

`endif

// ==== source/swerve_pkg.sv ====
// Swerve register file types
// Vector typedefs shared by the decode, execute and result stages
`include "swerve_consts.svh"

package swerve_pkg;

    // Host bus
    typedef logic [5:0] reg_addr_t;   // Register address
    typedef logic [7:0] reg_data_t;   // One register byte

    // Drive motor PWM duty, low bits of the drive control byte
    typedef logic [4:0] pwm_duty_t;

    // Rotation angle, 12 bits split over two registers
    typedef logic [11:0] angle_t;

    // Motor temperature from the ADC
    typedef logic [6:0] adc_temp_t;

    // One bit per writable register
    // Drive 0-3, rotation control 0-3, target low 0-3, servo 0-3
    typedef logic [`SWERVE_NUM_CTRL-1:0] ctrl_sel_t;

endpackage

// ==== source/swerve_wr_if.sv ====
// Write bus between the register file stages
// Decoded selects and commands forward, control bytes back for readback
`include "swerve_consts.svh"

interface swerve_wr_if;

    swerve_pkg::ctrl_sel_t wr_sel;    // Registers to load this cycle
    swerve_pkg::reg_data_t wr_byte;   // Byte to load
    logic                  cmd_valid; // Angle command strobe
    logic [1:0]            cmd_chan;  // Rotation channel of the command
    logic                  cmd_update;
    logic                  cmd_abort;

    // Current control register contents
    swerve_pkg::reg_data_t [`SWERVE_NUM_CTRL-1:0] ctrl_bytes;

    modport decode (
        output wr_sel, wr_byte, cmd_valid, cmd_chan, cmd_update, cmd_abort
    );

    modport execute (
        input  wr_sel, wr_byte, cmd_valid, cmd_chan, cmd_update, cmd_abort,
        output ctrl_bytes
    );

    modport result (
        input ctrl_bytes
    );

endinterface

// ==== source/swerve_write_decode.sv ====
// Write address decoder
// Host writes to register selects, broadcasts included, and angle commands
`include "swerve_consts.svh"

module swerve_write_decode (
    input  swerve_pkg::reg_addr_t address,
    input  logic                  write_en,
    input  swerve_pkg::reg_data_t wr_data,
    swerve_wr_if.decode           wr
);

    logic bcast_all; // 0x01 hit
    logic bcast_rot; // 0x02 hit
    logic bcast_drv; // 0x03 hit

    assign bcast_all = (address == `SWERVE_ADDR_ALL);
    assign bcast_rot = (address == `SWERVE_ADDR_ROT_ALL);
    assign bcast_drv = (address == `SWERVE_ADDR_DRV_ALL);

    // Same byte goes to every selected register
    assign wr.wr_byte    = wr_data;
    assign wr.cmd_update = wr_data[`SWERVE_BIT_UPDATE];
    assign wr.cmd_abort  = wr_data[`SWERVE_BIT_ABORT];

    always_comb begin
        wr.wr_sel    = '0;
        wr.cmd_valid = 1'b0;
        wr.cmd_chan  = '0;

        // Drive control, own address or drive/all broadcast
        for (int n = 0; n < `SWERVE_NUM_DRV; n++) begin
            wr.wr_sel[`SWERVE_SEL_DRV + n] = write_en &
                ((address == swerve_pkg::reg_addr_t'(`SWERVE_DRV_BASE + 2 * n)) |
                 bcast_all | bcast_drv);
        end

        for (int n = 0; n < `SWERVE_NUM_ROT; n++) begin
            // Rotation control, own address or rotation/all broadcast
            wr.wr_sel[`SWERVE_SEL_ROT + n] = write_en &
                ((address == swerve_pkg::reg_addr_t'(`SWERVE_ROT_BASE +
                  `SWERVE_ROT_STRIDE * n + `SWERVE_ROT_CTRL_OFS)) |
                 bcast_all | bcast_rot);

            // Target low byte only by its own address
            wr.wr_sel[`SWERVE_SEL_TGT + n] = write_en &
                (address == swerve_pkg::reg_addr_t'(`SWERVE_ROT_BASE +
                 `SWERVE_ROT_STRIDE * n + `SWERVE_ROT_TGT_OFS));

            // Current angle high byte doubles as command register
            if (write_en && (address == swerve_pkg::reg_addr_t'(`SWERVE_ROT_BASE +
                    `SWERVE_ROT_STRIDE * n + `SWERVE_ROT_CURH_OFS))) begin
                wr.cmd_valid = 1'b1;
                wr.cmd_chan  = n[1:0];
            end
        end

        // Servo positions, no broadcast
        for (int n = 0; n < `SWERVE_NUM_SERVO; n++) begin
            wr.wr_sel[`SWERVE_SEL_SERVO + n] = write_en &
                (address == swerve_pkg::reg_addr_t'(`SWERVE_SERVO_BASE + n));
        end
    end

endmodule

// ==== source/swerve_control_regs.sv ====
// Control register bank
// Holds the writable bytes, maps them onto motor outputs, issues angle strobes
`include "swerve_consts.svh"

module swerve_control_regs (
    input  logic                  clock,
    input  logic                  arst_n,
    swerve_wr_if.execute          wr,

    output logic [`SWERVE_NUM_MOTOR-1:0] brake,     // Drive 0-3, rotation 4-7
    output logic [`SWERVE_NUM_MOTOR-1:0] enable,
    output logic [`SWERVE_NUM_MOTOR-1:0] direction,
    output swerve_pkg::pwm_duty_t [`SWERVE_NUM_DRV-1:0]   pwm,
    output swerve_pkg::angle_t    [`SWERVE_NUM_ROT-1:0]   target_angle,
    output swerve_pkg::reg_data_t [`SWERVE_NUM_SERVO-1:0] servo_position,
    output logic [`SWERVE_NUM_ROT-1:0]   update_angle, // One cycle pulses
    output logic [`SWERVE_NUM_ROT-1:0]   abort_angle
);

    swerve_pkg::reg_data_t [`SWERVE_NUM_CTRL-1:0] ctrl_q;

    // Byte load, any number of selects at once for broadcasts
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q <= '0;
        end else begin
            for (int i = 0; i < `SWERVE_NUM_CTRL; i++) begin
                if (wr.wr_sel[i])
                    ctrl_q[i] <= wr.wr_byte;
            end
        end
    end

    assign wr.ctrl_bytes = ctrl_q; // Readback path

    // Angle command strobes, clear themselves the cycle after
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            update_angle <= '0;
            abort_angle  <= '0;
        end else begin
            update_angle <= '0;
            abort_angle  <= '0;
            if (wr.cmd_valid) begin
                update_angle[wr.cmd_chan] <= wr.cmd_update;
                abort_angle[wr.cmd_chan]  <= wr.cmd_abort;
            end
        end
    end

    always_comb begin
        // Drive motors take the low output bits
        for (int n = 0; n < `SWERVE_NUM_DRV; n++) begin
            brake[n]     = ctrl_q[`SWERVE_SEL_DRV + n][`SWERVE_BIT_BRAKE];
            enable[n]    = ctrl_q[`SWERVE_SEL_DRV + n][`SWERVE_BIT_ENABLE];
            direction[n] = ctrl_q[`SWERVE_SEL_DRV + n][`SWERVE_BIT_DIR];
            pwm[n]       = swerve_pkg::pwm_duty_t'(ctrl_q[`SWERVE_SEL_DRV + n]); // Bits 4:0
        end

        // Rotation motors above them
        for (int n = 0; n < `SWERVE_NUM_ROT; n++) begin
            brake[`SWERVE_NUM_DRV + n]     = ctrl_q[`SWERVE_SEL_ROT + n][`SWERVE_BIT_BRAKE];
            enable[`SWERVE_NUM_DRV + n]    = ctrl_q[`SWERVE_SEL_ROT + n][`SWERVE_BIT_ENABLE];
            direction[`SWERVE_NUM_DRV + n] = ctrl_q[`SWERVE_SEL_ROT + n][`SWERVE_BIT_DIR];

            // High nibble from control byte, low byte from its own register
            target_angle[n] = {ctrl_q[`SWERVE_SEL_ROT + n][3:0],
                               ctrl_q[`SWERVE_SEL_TGT + n]};
        end

        for (int n = 0; n < `SWERVE_NUM_SERVO; n++) begin
            servo_position[n] = ctrl_q[`SWERVE_SEL_SERVO + n];
        end
    end

endmodule

// ==== source/swerve_status_read.sv ====
// Status capture and read port
// Samples motor status every cycle, returns status or control bytes by address
`include "swerve_consts.svh"

module swerve_status_read (
    input  logic                  clock,
    input  logic                  arst_n,
    input  swerve_pkg::reg_addr_t address,
    input  logic                  read_en,
    output swerve_pkg::reg_data_t rd_data,

    input  logic [`SWERVE_NUM_MOTOR-1:0]                  fault,
    input  swerve_pkg::adc_temp_t [`SWERVE_NUM_MOTOR-1:0] adc_temp,
    input  logic [`SWERVE_NUM_ROT-1:0]                    startup_fail,
    input  swerve_pkg::angle_t    [`SWERVE_NUM_ROT-1:0]   current_angle,
    input  logic [`SWERVE_NUM_ROT-1:0]                    angle_done,

    swerve_wr_if.result           wr
);

    swerve_pkg::reg_data_t [`SWERVE_NUM_DRV-1:0] drv_stat_q; // {fault, temp}
    swerve_pkg::reg_data_t [`SWERVE_NUM_ROT-1:0] rot_stat_q; // {fault, stall, temp 5:0}
    swerve_pkg::reg_data_t [`SWERVE_NUM_ROT-1:0] cur_lo_q;
    swerve_pkg::reg_data_t [`SWERVE_NUM_ROT-1:0] cur_hi_q;   // {done, 000, angle 11:8}
    swerve_pkg::reg_data_t                       rd_next;

    // Free running capture, one cycle behind the inputs
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            drv_stat_q <= '0;
            rot_stat_q <= '0;
            cur_lo_q   <= '0;
            cur_hi_q   <= '0;
        end else begin
            for (int n = 0; n < `SWERVE_NUM_DRV; n++) begin
                drv_stat_q[n] <= {fault[n], adc_temp[n]};
            end
            for (int n = 0; n < `SWERVE_NUM_ROT; n++) begin
                rot_stat_q[n] <= {fault[`SWERVE_NUM_DRV + n], startup_fail[n],
                                  adc_temp[`SWERVE_NUM_DRV + n][5:0]};
                cur_lo_q[n]   <= current_angle[n][7:0];
                cur_hi_q[n]   <= {angle_done[n], 3'b000, current_angle[n][11:8]};
            end
        end
    end

    // Read mux, anything unmatched stays zero
    always_comb begin
        rd_next = '0;

        for (int n = 0; n < `SWERVE_NUM_DRV; n++) begin
            if (address == swerve_pkg::reg_addr_t'(`SWERVE_DRV_BASE + 2 * n))
                rd_next = wr.ctrl_bytes[`SWERVE_SEL_DRV + n];
            if (address == swerve_pkg::reg_addr_t'(`SWERVE_DRV_BASE + 2 * n + 1))
                rd_next = drv_stat_q[n];
        end

        for (int n = 0; n < `SWERVE_NUM_ROT; n++) begin
            case (address - swerve_pkg::reg_addr_t'(`SWERVE_ROT_BASE + `SWERVE_ROT_STRIDE * n))
                swerve_pkg::reg_addr_t'(`SWERVE_ROT_CTRL_OFS):
                    rd_next = wr.ctrl_bytes[`SWERVE_SEL_ROT + n];
                swerve_pkg::reg_addr_t'(`SWERVE_ROT_STAT_OFS):
                    rd_next = rot_stat_q[n];
                swerve_pkg::reg_addr_t'(`SWERVE_ROT_TGT_OFS):
                    rd_next = wr.ctrl_bytes[`SWERVE_SEL_TGT + n];
                swerve_pkg::reg_addr_t'(`SWERVE_ROT_CURL_OFS):
                    rd_next = cur_lo_q[n];
                swerve_pkg::reg_addr_t'(`SWERVE_ROT_CURH_OFS):
                    rd_next = cur_hi_q[n]; // Status view, writes here are commands
                default: ;
            endcase
        end

        for (int n = 0; n < `SWERVE_NUM_SERVO; n++) begin
            if (address == swerve_pkg::reg_addr_t'(`SWERVE_SERVO_BASE + n))
                rd_next = wr.ctrl_bytes[`SWERVE_SEL_SERVO + n];
        end
    end

    // Registered read port, holds between reads
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            rd_data <= '0;
        else if (read_en)
            rd_data <= rd_next;
    end

endmodule

// ==== source/swerve_regs_top.sv ====
// Swerve drive register file top level
// Write decode, control registers and status read joined over one write bus
`include "swerve_consts.svh"

module swerve_regs_top (
    input  logic                  clock,
    input  logic                  arst_n,

    // Host port
    input  swerve_pkg::reg_addr_t address,
    input  logic                  write_en,
    input  swerve_pkg::reg_data_t wr_data,
    input  logic                  read_en,
    output swerve_pkg::reg_data_t rd_data,

    // Motor status
    input  logic [`SWERVE_NUM_MOTOR-1:0]                  fault,
    input  swerve_pkg::adc_temp_t [`SWERVE_NUM_MOTOR-1:0] adc_temp,
    input  logic [`SWERVE_NUM_ROT-1:0]                    startup_fail,
    input  swerve_pkg::angle_t    [`SWERVE_NUM_ROT-1:0]   current_angle,
    input  logic [`SWERVE_NUM_ROT-1:0]                    angle_done,

    // Motor control
    output logic [`SWERVE_NUM_MOTOR-1:0]                  brake,
    output logic [`SWERVE_NUM_MOTOR-1:0]                  enable,
    output logic [`SWERVE_NUM_MOTOR-1:0]                  direction,
    output swerve_pkg::pwm_duty_t [`SWERVE_NUM_DRV-1:0]   pwm,
    output swerve_pkg::angle_t    [`SWERVE_NUM_ROT-1:0]   target_angle,
    output swerve_pkg::reg_data_t [`SWERVE_NUM_SERVO-1:0] servo_position,
    output logic [`SWERVE_NUM_ROT-1:0]                    update_angle,
    output logic [`SWERVE_NUM_ROT-1:0]                    abort_angle
);

    swerve_wr_if wr_bus (); // Decode to execute, control bytes back to read

    // Host writes into selects and commands
    swerve_write_decode u_decode (
        .address  (address),
        .write_en (write_en),
        .wr_data  (wr_data),
        .wr       (wr_bus.decode)
    );

    swerve_control_regs u_ctrl (
        .clock          (clock),
        .arst_n         (arst_n),
        .wr             (wr_bus.execute),
        .brake          (brake),
        .enable         (enable),
        .direction      (direction),
        .pwm            (pwm),
        .target_angle   (target_angle),
        .servo_position (servo_position),
        .update_angle   (update_angle),
        .abort_angle    (abort_angle)
    );

    // Status capture and readback
    swerve_status_read u_read (
        .clock         (clock),
        .arst_n        (arst_n),
        .address       (address),
        .read_en       (read_en),
        .rd_data       (rd_data),
        .fault         (fault),
        .adc_temp      (adc_temp),
        .startup_fail  (startup_fail),
        .current_angle (current_angle),
        .angle_done    (angle_done),
        .wr            (wr_bus.result)
    );

endmodule

// ==== sim/swerve_clock_gen.sv ====
// Testbench clock and reset source
// Period of 10, reset held low for the first 5 cycles
module swerve_clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock  = 1'b0;
        arst_n = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        repeat (5) @(posedge clock);
        @(negedge clock) arst_n = 1'b1; // Release away from the sampling edge
    end

endmodule

// ==== sim/swerve_regs_chk.sv ====
// Register file protocol checker
// Strobe width, read hold and reset value rules on the top level
module swerve_regs_chk (
    input logic       clock,
    input logic       arst_n,
    input logic       read_en,
    input logic [7:0] rd_data,
    input logic [3:0] update_angle,
    input logic [3:0] abort_angle,
    input logic [7:0] brake,
    input logic [7:0] enable,
    input logic [7:0] direction
);

    // No strobe bit high two cycles running
    strobe_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
        ((update_angle & $past(update_angle)) == 4'h0) &&
        ((abort_angle & $past(abort_angle)) == 4'h0))
        else $error("angle strobe held longer than one cycle");

    // Read port holds when not reading
    read_hold: assert property (@(posedge clock) disable iff (!arst_n)
        !read_en |=> $stable(rd_data))
        else $error("rd_data changed without read_en");

    reset_zero: assert property (@(posedge clock)
        !arst_n |-> (rd_data == 8'h00 && update_angle == 4'h0 && abort_angle == 4'h0 &&
                     brake == 8'h00 && enable == 8'h00 && direction == 8'h00))
        else $error("outputs not zero during reset");

endmodule

bind swerve_regs_top swerve_regs_chk chk (
    .clock        (clock),
    .arst_n       (arst_n),
    .read_en      (read_en),
    .rd_data      (rd_data),
    .update_angle (update_angle),
    .abort_angle  (abort_angle),
    .brake        (brake),
    .enable       (enable),
    .direction    (direction)
);

// ==== sim/swerve_regs_tb.sv ====
// Swerve register file testbench
// Random host traffic checked against a model of the control bytes and status map
`include "swerve_consts.svh"

module swerve_regs_tb;

    localparam int TEST_CYCLES = 1000; // Upper bound over all five tests
    localparam int PERIOD      = 10;

    logic clock, arst_n;
    swerve_pkg::reg_addr_t address;
    logic write_en, read_en;
    swerve_pkg::reg_data_t wr_data, rd_data;
    logic [7:0] fault;
    swerve_pkg::adc_temp_t [7:0] adc_temp;
    logic [3:0] startup_fail, angle_done;
    swerve_pkg::angle_t [3:0] current_angle;
    logic [7:0] brake, enable, direction;
    swerve_pkg::pwm_duty_t [3:0] pwm;
    swerve_pkg::angle_t [3:0] target_angle;
    swerve_pkg::reg_data_t [3:0] servo_position;
    logic [3:0] update_angle, abort_angle;

    logic [7:0]  model_ctrl [16]; // Mirror of the writable registers
    logic [15:0] lfsr_state = 16'd27;
    int errors = 0, test_errors = 0, tests = 0, checks = 0;

    swerve_clock_gen clk_gen (.clock(clock), .arst_n(arst_n));

    swerve_regs_top UUT (.*);

    // Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // Index order: drive ctrl, rotation ctrl, target low, servo
    function automatic logic [5:0] addr_of_index(input int i);
        if (i < 4) return 6'(`SWERVE_DRV_BASE + 2 * i);
        if (i < 8) return 6'(`SWERVE_ROT_BASE + 5 * (i - 4));
        if (i < 12) return 6'(`SWERVE_ROT_BASE + 5 * (i - 8) + 2);
        return 6'(`SWERVE_SERVO_BASE + i - 12);
    endfunction

    // Expected read value from the model and the held status inputs
    function automatic logic [7:0] expected_read(input logic [5:0] a);
        for (int i = 0; i < 16; i++)
            if (a == addr_of_index(i)) return model_ctrl[i];
        for (int n = 0; n < 4; n++) begin
            if (a == 6'(`SWERVE_DRV_BASE + 2 * n + 1)) return {fault[n], adc_temp[n]};
            if (a == 6'(`SWERVE_ROT_BASE + 5 * n + 1))
                return {fault[4 + n], startup_fail[n], adc_temp[4 + n][5:0]};
            if (a == 6'(`SWERVE_ROT_BASE + 5 * n + 3)) return current_angle[n][7:0];
            if (a == 6'(`SWERVE_ROT_BASE + 5 * n + 4))
                return {angle_done[n], 3'b000, current_angle[n][11:8]};
        end
        return 8'h00; // Broadcast, reserved, unmapped
    endfunction

    task automatic write_reg(input logic [5:0] a, input logic [7:0] d);
        @(negedge clock);
        address  = a;
        wr_data  = d;
        write_en = 1'b1;
        @(negedge clock);
        write_en = 1'b0;
        for (int i = 0; i < 16; i++) begin
            if (a == addr_of_index(i) || (a == 6'h01 && i < 8) ||
                (a == 6'h02 && i >= 4 && i < 8) || (a == 6'h03 && i < 4))
                model_ctrl[i] = d;
        end
    endtask

    task automatic read_check(input string name, input logic [5:0] a);
        @(negedge clock);
        address = a;
        read_en = 1'b1;
        @(negedge clock);
        read_en = 1'b0;
        compare(name, 64'(expected_read(a)), 64'(rd_data));
    endtask

    task automatic check_outputs(input string name);
        logic [7:0] e_brk, e_en, e_dir;
        logic [19:0] e_pwm;
        logic [47:0] e_tgt;
        logic [31:0] e_srv;
        for (int n = 0; n < 8; n++) begin
            e_brk[n] = model_ctrl[n][7];
            e_en[n]  = model_ctrl[n][6];
            e_dir[n] = model_ctrl[n][5];
        end
        for (int n = 0; n < 4; n++) begin
            e_pwm[5 * n +: 5]  = model_ctrl[n][4:0];
            e_tgt[12 * n +: 12] = {model_ctrl[4 + n][3:0], model_ctrl[8 + n]};
            e_srv[8 * n +: 8]  = model_ctrl[12 + n];
        end
        compare({name, " brake"}, 64'(e_brk), 64'(brake));
        compare({name, " enable"}, 64'(e_en), 64'(enable));
        compare({name, " direction"}, 64'(e_dir), 64'(direction));
        compare({name, " pwm"}, 64'(e_pwm), 64'(pwm));
        compare({name, " target"}, 64'(e_tgt), 64'(target_angle));
        compare({name, " servo"}, 64'(e_srv), 64'(servo_position));
    endtask

    initial begin
        #(TEST_CYCLES * PERIOD + 200 * PERIOD);
        $display("ERRORS FOUND");
        $display("watchdog expired before the tests completed");
        $finish;
    end

    initial begin
        logic [31:0] r, d;
        address       = '0;
        write_en      = 1'b0;
        read_en       = 1'b0;
        wr_data       = '0;
        fault         = '0;
        adc_temp      = '0;
        startup_fail  = '0;
        angle_done    = '0;
        current_angle = '0;
        for (int i = 0; i < 16; i++) model_ctrl[i] = 8'h00;
        @(posedge arst_n);

        check_outputs("reset");
        compare("reset strobes", 64'h0, 64'({update_angle, abort_angle}));
        for (int a = 0; a < 64; a++) read_check("reset read", 6'(a));
        end_test("reset");

        for (int k = 0; k < 24; k++) begin
            r = take_bits(4);
            d = take_bits(8);
            write_reg(addr_of_index(int'(r)), d[7:0]);
            check_outputs("direct");
            read_check("direct read", addr_of_index(int'(r)));
        end
        end_test("direct");

        for (int b = 1; b <= 3; b++) begin
            d = take_bits(8);
            write_reg(6'(b), d[7:0]);
            check_outputs("broadcast");
            for (int i = 0; i < 16; i++) read_check("broadcast read", addr_of_index(i));
        end
        end_test("broadcast");

        for (int k = 0; k < 12; k++) begin
            r = take_bits(2);
            d = take_bits(8);
            write_reg(6'(`SWERVE_ROT_BASE + 5 * r + 4), d[7:0]); // Edge k just passed
            compare("cmd update", 64'(4'(d[5]) << r[1:0]), 64'(update_angle));
            compare("cmd abort", 64'(4'(d[4]) << r[1:0]), 64'(abort_angle));
            @(negedge clock);
            compare("cmd clear", 64'h0, 64'({update_angle, abort_angle}));
            check_outputs("cmd");
        end
        end_test("angle commands");

        for (int k = 0; k < 4; k++) begin
            @(negedge clock);
            r = take_bits(8);
            fault = r[7:0];
            for (int n = 0; n < 8; n++) begin
                r = take_bits(7);
                adc_temp[n] = r[6:0];
            end
            r = take_bits(4);
            startup_fail = r[3:0];
            r = take_bits(4);
            angle_done = r[3:0];
            for (int n = 0; n < 4; n++) begin
                r = take_bits(12);
                current_angle[n] = r[11:0];
            end
            @(negedge clock); // Two cycles held before the reads
            for (int a = 4; a < 32; a++) read_check("status read", 6'(a));
            r = take_bits(4);
            read_check("unmapped read", 6'h20 + 6'(r));
            read_check("unmapped read", 6'h34 + 6'(r[2:0]));
            read_check("broadcast addr read", 6'(1 + r[0]));
        end
        end_test("status readback");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/swerve_pkg.sv
source/swerve_wr_if.sv
source/swerve_write_decode.sv
source/swerve_control_regs.sv
source/swerve_status_read.sv
source/swerve_regs_top.sv
sim/swerve_clock_gen.sv
sim/swerve_regs_chk.sv
sim/swerve_regs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register file testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Isource -f verilog.f \
    --top-module swerve_regs_tb -o swerve_sim > build.log 2>&1 \
    || { cat build.log; echo "ERRORS FOUND" > sim.log; }
[ -f sim.log ] || { ./obj_dir/swerve_sim > sim.log 2>&1 \
    || echo "ERRORS FOUND" >> sim.log; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
